// File: filelist.f
titan_pkg.sv
titan_stage_if.sv
titan_if_stage.sv
titan_regfile.sv
titan_forwarding_unit.sv
titan_id_stage.sv
titan_ex_stage.sv
titan_wb_stage.sv
titan_core.sv
tb_titan_core.sv

// File: Bender.yml
package:
  name: titan_core

sources:
  - titan_pkg.sv
  - titan_stage_if.sv
  - titan_if_stage.sv
  - titan_regfile.sv
  - titan_forwarding_unit.sv
  - titan_id_stage.sv
  - titan_ex_stage.sv
  - titan_wb_stage.sv
  - titan_core.sv
  - target: test
    files:
      - tb_titan_core.sv

// File: titan_core_stim.txt
# instr(hex) rd(dec) data(hex) illegal(0/1) gap_ok(0/1)
# gap_ok 0 sends the word right after the previous one, data is ignored for illegal words
00500093 1 00000005 0 1
FFD00113 2 FFFFFFFD 0 0
002081B3 3 00000002 0 0
40208233 4 00000008 0 0
404182B3 5 FFFFFFFA 0 0
0020F333 6 00000005 0 1
0020E3B3 7 FFFFFFFD 0 1
0020C433 8 FFFFFFF8 0 1
001094B3 9 000000A0 0 1
00115533 10 07FFFFFF 0 1
401155B3 11 FFFFFFFF 0 1
00112633 12 00000001 0 1
001136B3 13 00000000 0 1
FFF0A713 14 00000000 0 1
FFF0B793 15 00000001 0 1
0F00C813 16 000000F5 0 1
70086893 17 000007F5 0 0
0FF8F913 18 000000F5 0 0
00409993 19 00000050 0 1
01C15A13 20 0000000F 0 1
40115A93 21 FFFFFFFE 0 1
00708013 0 0000000C 0 1
00000B33 22 00000000 0 0
12345BB7 23 12345000 0 1
678B8C13 24 12345678 0 0
00012083 1 00000000 1 1
021080B3 1 00000000 1 0
4010E133 2 00000000 1 0
40109093 1 00000000 1 0
00208CB3 25 00000002 0 0
00008D33 26 00000005 0 1
417C0DB3 27 00000678 0 1

// File: tb_titan_core.sv
// Testbench for the titan integer pipeline
// Replays the stim file through the credit port, checks retirements in order

`timescale 1ns/1ps

module tb_titan_core import titan_pkg::*; ();

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  instr_valid;
	logic [XLEN-1:0]       instr;
	logic                  credit;
	logic                  retire_valid;
	logic [XLEN-1:0]       retire_pc;
	logic [REG_ADDR_W-1:0] retire_rd;
	logic [XLEN-1:0]       retire_data;
	logic                  retire_illegal;

	// One entry per stim line
	logic [XLEN-1:0]       stim_instr [$];
	logic [REG_ADDR_W-1:0] exp_rd [$];
	logic [XLEN-1:0]       exp_data [$];
	logic                  exp_illegal [$];
	logic                  gap_ok [$];

	int errors;
	int sent;
	int credits_back;
	int retired;

	// Words pushed in the last two cycles, newest in bit 0
	logic [1:0] push_hist;

	// Same value as the RESET_ADDR given to dut
	logic [XLEN-1:0] boot_pc = 32'h0000_1000;

	initial begin
		forever #20 clk = ~clk;
	end

	titan_core #(
		.RESET_ADDR(32'h0000_1000)
	) dut (
		.clk_i(clk), .rst_n_i(rst_n),
		.instr_valid_i(instr_valid), .instr_i(instr), .credit_o(credit),
		.retire_valid_o(retire_valid), .retire_pc_o(retire_pc),
		.retire_rd_o(retire_rd), .retire_data_o(retire_data),
		.retire_illegal_o(retire_illegal)
	);

	function automatic int host_credits();
		return FETCH_DEPTH - sent + credits_back;
	endfunction

	task automatic show_mismatch(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
		errors++;
		$display("Fail %s: expected %h, actual %h", name, exp, act);
	endtask

	// ----------------------------------------
	// Stim file
	// ----------------------------------------
	task automatic load_stim();
		int              fd;
		int              n;
		string           line;
		logic [XLEN-1:0] word;
		int              rd;
		logic [XLEN-1:0] data;
		int              ill;
		int              gap;
		fd = $fopen("titan_core_stim.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Error: could not open titan_core_stim.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0)
				break;
			// Comments and blank lines
			if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
				continue;
			n = $sscanf(line, "%h %d %h %d %d", word, rd, data, ill, gap);
			if (n != 5) begin
				errors++;
				$display("Error: malformed stim line: %s", line);
			end else begin
				stim_instr.push_back(word);
				exp_rd.push_back(REG_ADDR_W'(rd));
				exp_data.push_back(data);
				exp_illegal.push_back(ill != 0);
				gap_ok.push_back(gap != 0);
			end
		end
		$fclose(fd);
		if (stim_instr.size() == 0) begin
			errors++;
			$display("Error: stim file holds no instructions");
		end
	endtask

	// In-order retirement check, PCs four bytes apart from the boot PC
	task automatic check_retirement();
		logic [XLEN-1:0] exp_pc;
		string           tag;
		exp_pc = boot_pc + XLEN'(4 * retired);
		if (retired >= stim_instr.size()) begin
			errors++;
			$display("Error: retirement at pc %h with no instruction left to retire",
				retire_pc);
		end else begin
			tag = $sformatf("word %0d", retired);
			if (retire_pc !== exp_pc)
				show_mismatch({tag, " pc"}, exp_pc, retire_pc);
			if (retire_rd !== exp_rd[retired])
				show_mismatch({tag, " rd"}, XLEN'(exp_rd[retired]), XLEN'(retire_rd));
			if (retire_illegal !== exp_illegal[retired])
				show_mismatch({tag, " illegal"}, XLEN'(exp_illegal[retired]),
					XLEN'(retire_illegal));
			if (!exp_illegal[retired] && (retire_data !== exp_data[retired]))
				show_mismatch({tag, " data"}, exp_data[retired], retire_data);
		end
		retired++;
	endtask

	// ----------------------------------------
	// Output monitor, samples mid-cycle
	// ----------------------------------------
	always @(negedge clk) begin
		if (!rst_n) begin
			push_hist = 2'b00;
			if ((retire_valid !== 1'b0) || (credit !== 1'b0)) begin
				errors++;
				$display("Error: retire_valid or credit not low during reset");
			end
		end else begin
			// A word taken at one edge returns its credit after the next edge
			if (credit !== push_hist[1])
				show_mismatch("credit timing", XLEN'(push_hist[1]), XLEN'(credit));
			push_hist = {push_hist[0], instr_valid};
			if (credit === 1'b1)
				credits_back++;
			if (credits_back > sent) begin
				errors++;
				$display("Error: more credits returned than words sent");
			end
			if (retire_valid === 1'b1)
				check_retirement();
			else if (retire_valid !== 1'b0) begin
				errors++;
				$display("Error: retire_valid is unknown");
			end
		end
	end

	// ----------------------------------------
	// Host driver
	// ----------------------------------------
	initial begin
		int unsigned seed_val;
		int          idle;
		int          wait_cnt;
		logic        timed_out;
		errors       = 0;
		sent         = 0;
		credits_back = 0;
		retired      = 0;
		timed_out    = 1'b0;
		rst_n        = 1'b0;
		instr_valid  = 1'b0;
		instr        = '0;
		seed_val     = $urandom(32'h62b);
		load_stim();

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		for (int i = 0; i < stim_instr.size() && !timed_out; i++) begin
			idle = gap_ok[i] ? int'($urandom % 4) : 0;
			repeat (idle) begin
				@(posedge clk);
				instr_valid <= 1'b0;
			end
			// Hold off until a credit is back
			wait_cnt = 0;
			while ((host_credits() == 0) && !timed_out) begin
				@(posedge clk);
				instr_valid <= 1'b0;
				wait_cnt++;
				if (wait_cnt > 50) begin
					timed_out = 1'b1;
					errors++;
					$display("Error: no credit returned within 50 cycles");
				end
			end
			if (!timed_out) begin
				@(posedge clk);
				instr_valid <= 1'b1;
				instr       <= stim_instr[i];
				sent++;
			end
		end
		@(posedge clk);
		instr_valid <= 1'b0;

		// Drain the pipeline
		wait_cnt = 0;
		while (!timed_out && ((retired < stim_instr.size()) || (credits_back < sent))) begin
			@(posedge clk);
			wait_cnt++;
			if (wait_cnt > 100) begin
				timed_out = 1'b1;
				errors++;
				$display("Error: pipeline did not drain within 100 cycles");
			end
		end
		// A few quiet cycles catch stray retirements
		repeat (4) @(posedge clk);

		if (credits_back != sent) begin
			errors++;
			$display("Error: %0d credits returned for %0d words sent", credits_back, sent);
		end
		if (retired != stim_instr.size()) begin
			errors++;
			$display("Error: %0d retirements for %0d instructions", retired,
				stim_instr.size());
		end

		$display("Errors: %0d, words sent: %0d, credits returned: %0d, retired: %0d",
			errors, sent, credits_back, retired);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: titan_core.sv
// Top level of the titan integer pipeline
// Fetch buffer, decode, execute, writeback, register file, forwarding

`timescale 1ns/1ps

module titan_core import titan_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_ADDR = 32'h8000_0000
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	// Host instruction input, credit based
	input  logic                  instr_valid_i,
	input  logic [XLEN-1:0]       instr_i,
	output logic                  credit_o,
	// Retire port, no back-pressure
	output logic                  retire_valid_o,
	output logic [XLEN-1:0]       retire_pc_o,
	output logic [REG_ADDR_W-1:0] retire_rd_o,
	output logic [XLEN-1:0]       retire_data_o,
	output logic                  retire_illegal_o
);

	titan_stage_if if2id ();
	titan_stage_if id2ex ();
	titan_stage_if ex2wb ();

	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic [XLEN-1:0]       rs1_data;
	logic [XLEN-1:0]       rs2_data;
	fwd_sel_e              fwd_a;
	fwd_sel_e              fwd_b;
	logic [XLEN-1:0]       ex_fwd_data;
	logic [XLEN-1:0]       wb_fwd_data;
	logic                  rf_we;
	logic [REG_ADDR_W-1:0] rf_waddr;
	logic [XLEN-1:0]       rf_wdata;

	// ----------------------------------------
	// Pipeline stages
	// ----------------------------------------
	titan_if_stage #(
		.RESET_ADDR(RESET_ADDR)
	) if_stage (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.instr_valid_i(instr_valid_i), .instr_i(instr_i),
		.credit_o(credit_o), .out(if2id)
	);

	titan_id_stage id_stage (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .in(if2id), .out(id2ex),
		.rs1_o(rs1), .rs2_o(rs2), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
		.fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
		.ex_fwd_data_i(ex_fwd_data), .wb_fwd_data_i(wb_fwd_data)
	);

	titan_ex_stage ex_stage (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .in(id2ex), .out(ex2wb),
		.ex_fwd_data_o(ex_fwd_data)
	);

	titan_wb_stage wb_stage (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .in(ex2wb),
		.rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
		.wb_fwd_data_o(wb_fwd_data),
		.retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
		.retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o),
		.retire_illegal_o(retire_illegal_o)
	);

	// Decode side helpers
	titan_regfile regfile (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.rs1_i(rs1), .rs2_i(rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
		.we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
	);

	titan_forwarding_unit fwd_unit (
		.rs1_i(rs1), .rs2_i(rs2),
		.ex_rd_i(id2ex.rd), .ex_we_i(id2ex.we),
		.wb_rd_i(ex2wb.rd), .wb_we_i(ex2wb.we),
		.fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
	);

endmodule

// File: titan_wb_stage.sv
// Register write-back
// Retire port and writeback forward path

`timescale 1ns/1ps

module titan_wb_stage import titan_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	titan_stage_if.receiver       in,
	output logic                  rf_we_o,
	output logic [REG_ADDR_W-1:0] rf_waddr_o,
	output logic [XLEN-1:0]       rf_wdata_o,
	output logic [XLEN-1:0]       wb_fwd_data_o,
	output logic                  retire_valid_o,
	output logic [XLEN-1:0]       retire_pc_o,
	output logic [REG_ADDR_W-1:0] retire_rd_o,
	output logic [XLEN-1:0]       retire_data_o,
	output logic                  retire_illegal_o
);

	// Write happens on the edge that ends the retire cycle
	assign rf_we_o       = in.valid && in.we;
	assign rf_waddr_o    = in.rd;
	assign rf_wdata_o    = in.result;
	assign wb_fwd_data_o = in.result;

	// ----------------------------------------
	// Retire port
	// ----------------------------------------
	assign retire_valid_o   = in.valid;
	assign retire_pc_o      = in.pc;
	assign retire_rd_o      = in.rd;
	assign retire_data_o    = in.result;
	assign retire_illegal_o = in.illegal;

	// Retirements come in program order, four bytes apart
	logic [XLEN-1:0] last_pc_q;
	logic            seen_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			seen_q <= 1'b0;
		end else if (in.valid) begin
			seen_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in.valid)
			last_pc_q <= in.pc;
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(in.valid && seen_q) |-> (in.pc == last_pc_q + XLEN'(4)))
		else $error("retire PC out of sequence");

endmodule

// File: titan_ex_stage.sv
// Integer ALU
// EX/WB pipeline register and execute forward path

`timescale 1ns/1ps

module titan_ex_stage import titan_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_n_i,
	titan_stage_if.receiver in,
	titan_stage_if.sender   out,
	output logic [XLEN-1:0] ex_fwd_data_o
);

	logic [XLEN-1:0]         alu_result;
	logic [$clog2(XLEN)-1:0] shamt;

	assign shamt = in.op_b[$clog2(XLEN)-1:0];

	// ----------------------------------------
	// ALU
	// ----------------------------------------
	always_comb begin
		case (in.alu_op)
			ALU_ADD:    alu_result = in.op_a + in.op_b;
			ALU_SUB:    alu_result = in.op_a - in.op_b;
			ALU_AND:    alu_result = in.op_a & in.op_b;
			ALU_OR:     alu_result = in.op_a | in.op_b;
			ALU_XOR:    alu_result = in.op_a ^ in.op_b;
			ALU_SLL:    alu_result = in.op_a << shamt;
			ALU_SRL:    alu_result = in.op_a >> shamt;
			ALU_SRA:    alu_result = XLEN'($signed(in.op_a) >>> shamt);
			ALU_SLT:    alu_result = XLEN'($signed(in.op_a) < $signed(in.op_b));
			ALU_SLTU:   alu_result = XLEN'(in.op_a < in.op_b);
			ALU_PASS_B: alu_result = in.op_b;
			default:    alu_result = '0;
		endcase
	end

	// Same-cycle forward to decode
	assign ex_fwd_data_o = alu_result;

	// EX/WB register
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			out.valid   <= 1'b0;
			out.we      <= 1'b0;
			out.illegal <= 1'b0;
		end else begin
			out.valid   <= in.valid;
			out.we      <= in.we;
			out.illegal <= in.illegal;
		end
	end

	always_ff @(posedge clk_i) begin
		out.pc     <= in.pc;
		out.rd     <= in.rd;
		out.result <= alu_result;
	end

	assign out.instr  = '0;
	assign out.op_a   = '0;
	assign out.op_b   = '0;
	assign out.alu_op = ALU_ADD;

	// Decode never hands an illegal word a write enable
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(in.valid && in.illegal) |-> !in.we)
		else $error("illegal instruction carries a register write");

endmodule

// File: titan_id_stage.sv
// Instruction decode and immediate generation
// Operand forward mux and ID/EX pipeline register

`timescale 1ns/1ps

module titan_id_stage import titan_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	titan_stage_if.receiver       in,
	titan_stage_if.sender         out,
	output logic [REG_ADDR_W-1:0] rs1_o,
	output logic [REG_ADDR_W-1:0] rs2_o,
	input  logic [XLEN-1:0]       rs1_data_i,
	input  logic [XLEN-1:0]       rs2_data_i,
	input  fwd_sel_e              fwd_a_i,
	input  fwd_sel_e              fwd_b_i,
	input  logic [XLEN-1:0]       ex_fwd_data_i,
	input  logic [XLEN-1:0]       wb_fwd_data_i
);

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	alu_op_e         alu_op;
	logic            is_reg;
	logic            f7_ok;
	logic            illegal;

	assign opcode = opcode_e'(in.instr[6:0]);
	assign funct3 = in.instr[14:12];
	assign funct7 = in.instr[31:25];
	assign rs1_o  = in.instr[19:15];
	assign rs2_o  = in.instr[24:20];
	assign imm_i  = {{(XLEN-12){in.instr[31]}}, in.instr[31:20]};
	assign imm_u  = {in.instr[31:12], 12'h000};
	assign is_reg = (opcode == OP_REG);

	// funct7 is either zero or the SUB/SRA variant
	assign f7_ok = (funct7 == 7'b0000000) || ((funct7 == 7'b0100000) &&
		((funct3 == 3'b101) || (is_reg && (funct3 == 3'b000))));

	// ----------------------------------------
	// Decoder
	// ----------------------------------------
	always_comb begin
		alu_op  = ALU_ADD;
		illegal = 1'b0;
		case (funct3)
			3'b000:  alu_op = (is_reg && funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001:  alu_op = ALU_SLL;
			3'b010:  alu_op = ALU_SLT;
			3'b011:  alu_op = ALU_SLTU;
			3'b100:  alu_op = ALU_XOR;
			3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110:  alu_op = ALU_OR;
			default: alu_op = ALU_AND;
		endcase
		case (opcode)
			OP_REG:  illegal = !f7_ok;
			// Only the shift immediates carry funct7
			OP_IMM:  illegal = ((funct3 == 3'b001) || (funct3 == 3'b101)) && !f7_ok;
			OP_LUI:  alu_op = ALU_PASS_B;
			default: illegal = 1'b1;
		endcase
	end

	function automatic logic [XLEN-1:0] fwd_mux(fwd_sel_e sel, logic [XLEN-1:0] rf_data);
		case (sel)
			FWD_EX:  return ex_fwd_data_i;
			FWD_WB:  return wb_fwd_data_i;
			default: return rf_data;
		endcase
	endfunction

	assign op_a    = fwd_mux(fwd_a_i, rs1_data_i);
	assign rs2_val = fwd_mux(fwd_b_i, rs2_data_i);
	assign op_b    = (opcode == OP_LUI) ? imm_u :
	                 (opcode == OP_IMM) ? imm_i : rs2_val;

	// ----------------------------------------
	// ID/EX register
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			out.valid   <= 1'b0;
			out.we      <= 1'b0;
			out.illegal <= 1'b0;
		end else begin
			out.valid   <= in.valid;
			out.we      <= in.valid && !illegal;
			out.illegal <= in.valid && illegal;
		end
	end

	always_ff @(posedge clk_i) begin
		out.pc     <= in.pc;
		out.rd     <= in.instr[11:7];
		out.op_a   <= op_a;
		out.op_b   <= op_b;
		out.alu_op <= alu_op;
	end

	assign out.instr  = '0;
	assign out.result = '0;

endmodule

// File: titan_forwarding_unit.sv
// Operand forwarding select
// Execute result wins over writeback, x0 never forwards

`timescale 1ns/1ps

module titan_forwarding_unit import titan_pkg::*; (
	input  logic [REG_ADDR_W-1:0] rs1_i,
	input  logic [REG_ADDR_W-1:0] rs2_i,
	input  logic [REG_ADDR_W-1:0] ex_rd_i,
	input  logic                  ex_we_i,
	input  logic [REG_ADDR_W-1:0] wb_rd_i,
	input  logic                  wb_we_i,
	output fwd_sel_e              fwd_a_o,
	output fwd_sel_e              fwd_b_o
);

	function automatic fwd_sel_e pick_source(logic [REG_ADDR_W-1:0] rs);
		if (rs == '0)
			return FWD_RF;
		// Youngest producer first
		if (ex_we_i && (ex_rd_i == rs))
			return FWD_EX;
		if (wb_we_i && (wb_rd_i == rs))
			return FWD_WB;
		return FWD_RF;
	endfunction

	assign fwd_a_o = pick_source(rs1_i);
	assign fwd_b_o = pick_source(rs2_i);

endmodule

// File: titan_regfile.sv
// Integer register file, x1..x31
// Two asynchronous reads, one synchronous write, x0 reads zero

`timescale 1ns/1ps

module titan_regfile import titan_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic [REG_ADDR_W-1:0] rs1_i,
	input  logic [REG_ADDR_W-1:0] rs2_i,
	output logic [XLEN-1:0]       rs1_data_o,
	output logic [XLEN-1:0]       rs2_data_o,
	input  logic                  we_i,
	input  logic [REG_ADDR_W-1:0] waddr_i,
	input  logic [XLEN-1:0]       wdata_i
);

	// No storage behind x0
	logic [XLEN-1:0] regs [1:(2**REG_ADDR_W)-1];

	// Writes to x0 are dropped
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Read ports
	always_comb begin
		rs1_data_o = '0;
		rs2_data_o = '0;
		if (rs1_i != '0)
			rs1_data_o = regs[rs1_i];
		if (rs2_i != '0)
			rs2_data_o = regs[rs2_i];
	end

endmodule

// File: titan_if_stage.sv
// Fetch buffer FIFO with PC counter
// Pops one word per cycle and returns a credit per pop

`timescale 1ns/1ps

module titan_if_stage import titan_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_ADDR = 32'h8000_0000
) (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            instr_valid_i,
	input  logic [XLEN-1:0] instr_i,
	output logic            credit_o,
	titan_stage_if.sender   out
);

	logic [XLEN-1:0]                  fifo_mem [FETCH_DEPTH];
	logic [$clog2(FETCH_DEPTH)-1:0]   wr_ptr_q;
	logic [$clog2(FETCH_DEPTH)-1:0]   rd_ptr_q;
	logic [CREDIT_W-1:0]              count_q;
	logic [XLEN-1:0]                  pc_q;
	logic                             out_valid_q;
	logic                             pop;

	assign pop = (count_q != '0);

	// ----------------------------------------
	// Pointers, fill level and PC
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			count_q     <= '0;
			pc_q        <= RESET_ADDR;
			out_valid_q <= 1'b0;
		end else begin
			if (instr_valid_i)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
				pc_q     <= pc_q + XLEN'(4);
			end
			count_q     <= count_q + CREDIT_W'(instr_valid_i) - CREDIT_W'(pop);
			out_valid_q <= pop;
		end
	end

	// Storage and outgoing word
	always_ff @(posedge clk_i) begin
		if (instr_valid_i)
			fifo_mem[wr_ptr_q] <= instr_i;
		if (pop) begin
			out.instr <= fifo_mem[rd_ptr_q];
			out.pc    <= pc_q;
		end
	end

	// Every word out of the buffer frees one host credit
	assign credit_o  = out_valid_q;
	assign out.valid = out_valid_q;

	// Fields owned by later stages
	assign out.rd      = '0;
	assign out.we      = 1'b0;
	assign out.illegal = 1'b0;
	assign out.op_a    = '0;
	assign out.op_b    = '0;
	assign out.alu_op  = ALU_ADD;
	assign out.result  = '0;

	// Host must never push beyond its credits
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		instr_valid_i |-> (count_q != CREDIT_W'(FETCH_DEPTH)))
		else $error("push into full fetch buffer");

endmodule

// File: titan_stage_if.sv
// Stage-to-stage instruction bundle
// Sender and receiver modports, no back-pressure

`timescale 1ns/1ps

interface titan_stage_if import titan_pkg::*; ();

	logic                  valid;
	logic [XLEN-1:0]       pc;
	logic [XLEN-1:0]       instr;
	logic [REG_ADDR_W-1:0] rd;
	logic                  we;
	logic                  illegal;
	logic [XLEN-1:0]       op_a;
	logic [XLEN-1:0]       op_b;
	alu_op_e               alu_op;
	logic [XLEN-1:0]       result;

	// Receiver always accepts when valid is high
	modport sender (
		output valid, pc, instr, rd, we, illegal,
		output op_a, op_b, alu_op, result
	);

	modport receiver (
		input valid, pc, instr, rd, we, illegal,
		input op_a, op_b, alu_op, result
	);

endinterface

// File: titan_pkg.sv
// Shared widths and depths for the titan integer pipeline
// RV32I major opcodes, ALU operations and operand forward sources

package titan_pkg;

	// ----------------------------------------
	// Widths and depths
	// ----------------------------------------
	localparam int XLEN        = 32;
	localparam int REG_ADDR_W  = 5;
	localparam int FETCH_DEPTH = 4;
	// Must hold 0..FETCH_DEPTH
	localparam int CREDIT_W    = 3;

	// ----------------------------------------
	// Encodings
	// ----------------------------------------
	// Major opcodes kept by this core
	typedef enum logic [6:0] {
		OP_REG = 7'b0110011,
		OP_IMM = 7'b0010011,
		OP_LUI = 7'b0110111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLL    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_SLT    = 4'd8,
		ALU_SLTU   = 4'd9,
		// LUI just passes the U immediate through
		ALU_PASS_B = 4'd10
	} alu_op_e;

	// Operand source picked by the forwarding unit
	typedef enum logic [1:0] {
		FWD_RF = 2'd0,
		FWD_EX = 2'd1,
		FWD_WB = 2'd2
	} fwd_sel_e;

endpackage
